// ==== verilog/rv_isa_pkg.sv ====
////////////////////////////////////////////////////////////
// RV32 ISA definitions for the pipeline front end
// Instruction and register index types, RV32I/M encodings
////////////////////////////////////////////////////////////

`default_nettype none

package rv_isa_pkg;

  // Raw instruction word
  typedef logic [31:0] instr_t;
  // Integer register index where zero selects x0
  typedef logic [4:0]  reg_idx_t;
  // Major opcode field, bits 6:0
  typedef logic [6:0]  opcode_t;
  // Minor opcode fields
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // Major opcodes in use
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;

  // funct7 of the M extension on OPC_OP
  localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

  // M extension funct3 encodings
  localparam funct3_t F3_MUL    = 3'b000;
  localparam funct3_t F3_MULH   = 3'b001;
  localparam funct3_t F3_MULHSU = 3'b010;
  localparam funct3_t F3_MULHU  = 3'b011;
  localparam funct3_t F3_DIV    = 3'b100;
  localparam funct3_t F3_DIVU   = 3'b101;
  localparam funct3_t F3_REM    = 3'b110;
  localparam funct3_t F3_REMU   = 3'b111;
  // Divides and remainders start here
  localparam funct3_t F3_DIV_FIRST = F3_DIV;

  // addi x0, x0, 0
  localparam instr_t NOP_INSTR = {12'h000, 5'd0, 3'b000, 5'd0, OPC_OP_IMM};

endpackage

`default_nettype wire

// ==== verilog/pipe_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// Pipeline control definitions
// PC type, reset vector, fetch step and M-unit latencies
////////////////////////////////////////////////////////////

`default_nettype none

package pipe_ctrl_pkg;

  // Program counter
  typedef logic [31:0] pc_t;
  // Down counter for the M-unit execute latency
  typedef logic [3:0]  lat_cnt_t;

  // PC after reset
  localparam pc_t RESET_PC = 32'h0000_0000;
  // No branches, so the PC only walks forward one word
  localparam pc_t PC_STEP  = 32'd4;

  // Cycles an M instruction spends in EX
  localparam int MUL_CYCLES = 4;
  localparam int DIV_CYCLES = 8;

endpackage

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
////////////////////////////////////////////////////////////
// Fetch stage
// Program counter and IF/ID register, both stallable
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall_pc,
  input  logic               stall_ifid,
  input  rv_isa_pkg::instr_t imem_rdata,
  output pipe_ctrl_pkg::pc_t imem_addr,
  output logic               ifid_valid,
  output pipe_ctrl_pkg::pc_t ifid_pc,
  output rv_isa_pkg::instr_t ifid_instr
);

  import pipe_ctrl_pkg::*;

  pc_t pc;
  pc_t pc_next;

  // Sequential fetch only
  assign pc_next = pc + PC_STEP;

  // Instruction memory answers in the same cycle
  assign imem_addr = pc;

  // Program counter
  // A stall repeats the same address next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!stall_pc) begin
      pc <= pc_next;
    end
  end

  // IF/ID valid bit
  // Rises on the first edge out of reset and stays up
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ifid_valid <= 1'b0;
    end else if (!stall_ifid) begin
      ifid_valid <= 1'b1;
    end
  end

  // IF/ID payload
  // Held during a stall so the word in ID is not lost
  always_ff @(posedge clk) begin
    if (!stall_ifid) begin
      ifid_pc    <= pc;
      ifid_instr <= imem_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
////////////////////////////////////////////////////////////
// Decode stage
// Source field decode, ID/EX register with bubble and hold,
// and the retire strobe for the entry leaving EX
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ifid_valid,
  input  pipe_ctrl_pkg::pc_t   ifid_pc,
  input  rv_isa_pkg::instr_t   ifid_instr,
  input  logic                 bubble_idex,
  input  logic                 hold_idex,
  output rv_isa_pkg::reg_idx_t ifid_rs1,
  output rv_isa_pkg::reg_idx_t ifid_rs2,
  output logic                 idex_mem_read,
  output logic                 idex_is_mul_div,
  output rv_isa_pkg::reg_idx_t idex_rd,
  output logic [2:0]           idex_funct3,
  output logic                 retire_valid,
  output pipe_ctrl_pkg::pc_t   retire_pc,
  output rv_isa_pkg::instr_t   retire_instr
);

  import rv_isa_pkg::*;
  import pipe_ctrl_pkg::*;

  opcode_t id_opcode;
  funct7_t id_funct7;
  logic    id_is_load;
  logic    id_is_mul_div;

  logic    idex_valid;
  pc_t     idex_pc;
  instr_t  idex_instr;

  // Field extraction from the word in ID
  assign id_opcode = ifid_instr[6:0];
  assign id_funct7 = ifid_instr[31:25];
  // Sources are taken from every format; the hazard unit compares both
  assign ifid_rs1  = ifid_instr[19:15];
  assign ifid_rs2  = ifid_instr[24:20];

  // Class decode, qualified by valid so an empty slot is harmless
  assign id_is_load    = ifid_valid && (id_opcode == OPC_LOAD);
  assign id_is_mul_div = ifid_valid && (id_opcode == OPC_OP) &&
                         (id_funct7 == FUNCT7_MULDIV);

  // ID/EX control bits
  // Hold wins over bubble; a bubble empties the slot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idex_valid      <= 1'b0;
      idex_mem_read   <= 1'b0;
      idex_is_mul_div <= 1'b0;
    end else if (!hold_idex) begin
      if (bubble_idex) begin
        idex_valid      <= 1'b0;
        idex_mem_read   <= 1'b0;
        idex_is_mul_div <= 1'b0;
      end else begin
        idex_valid      <= ifid_valid;
        idex_mem_read   <= id_is_load;
        idex_is_mul_div <= id_is_mul_div;
      end
    end
  end

  // ID/EX payload
  // Bubble writes a NOP with no destination
  always_ff @(posedge clk) begin
    if (!hold_idex) begin
      idex_pc <= ifid_pc;
      if (bubble_idex) begin
        idex_instr  <= NOP_INSTR;
        idex_rd     <= '0;
        idex_funct3 <= '0;
      end else begin
        idex_instr  <= ifid_instr;
        idex_rd     <= ifid_instr[11:7];
        idex_funct3 <= ifid_instr[14:12];
      end
    end
  end

  // Entry leaves EX when valid and not held by the M unit
  assign retire_valid = idex_valid && !hold_idex;
  assign retire_pc    = idex_pc;
  assign retire_instr = idex_instr;

endmodule

`default_nettype wire

// ==== verilog/hazard_detection_unit.sv ====
////////////////////////////////////////////////////////////
// Hazard detection unit
// Integer load-use check and multi-cycle M-unit stall
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hazard_detection_unit (
  input  logic                 idex_mem_read,
  input  rv_isa_pkg::reg_idx_t idex_rd,
  input  rv_isa_pkg::reg_idx_t ifid_rs1,
  input  rv_isa_pkg::reg_idx_t ifid_rs2,
  input  logic                 muldiv_busy,
  input  logic                 muldiv_done,
  input  logic                 idex_is_mul_div,
  output logic                 stall_pc,
  output logic                 stall_ifid,
  output logic                 bubble_idex
);

  logic rd_nonzero;
  logic rs1_match;
  logic rs2_match;
  logic load_use_hazard;
  logic m_stall;

  // x0 is never a real producer
  assign rd_nonzero = (idex_rd != '0);

  // Both sources checked regardless of format
  assign rs1_match = (idex_rd == ifid_rs1);
  assign rs2_match = (idex_rd == ifid_rs2);

  // Load in EX feeding the instruction in ID
  assign load_use_hazard = idex_mem_read && rd_nonzero && (rs1_match || rs2_match);

  // M instruction in EX or unit still counting
  // Released on done so a second M can follow without deadlock
  assign m_stall = (muldiv_busy || idex_is_mul_div) && !muldiv_done;

  // Front of the pipe freezes on either cause
  assign stall_pc   = load_use_hazard || m_stall;
  assign stall_ifid = load_use_hazard || m_stall;

  // Only load-use empties ID/EX; the M case holds it instead
  assign bubble_idex = load_use_hazard;

endmodule

`default_nettype wire

// ==== verilog/muldiv_sequencer.sv ====
////////////////////////////////////////////////////////////
// Mul/div latency sequencer
// Keeps an M instruction in EX for its funct3 latency
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module muldiv_sequencer (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       idex_is_mul_div,
  input  logic [2:0] idex_funct3,
  output logic       muldiv_busy,
  output logic       muldiv_done,
  output logic       hold_idex
);

  import rv_isa_pkg::*;
  import pipe_ctrl_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_COUNT
  } seq_state_t;

  seq_state_t state;
  lat_cnt_t   cnt;
  lat_cnt_t   lat_load;
  logic       start;
  logic       last;

  // New M instruction seen in EX while idle
  assign start = (state == ST_IDLE) && idex_is_mul_div;

  // First EX cycle is the start cycle itself, so load latency minus one
  assign lat_load = (idex_funct3 >= F3_DIV_FIRST) ? lat_cnt_t'(DIV_CYCLES - 1) :
                                                    lat_cnt_t'(MUL_CYCLES - 1);

  // Final EX cycle of the instruction
  assign last = (state == ST_COUNT) && (cnt == lat_cnt_t'(1));

  // State machine
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_COUNT;
          end
        end
        ST_COUNT: begin
          if (last) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Down counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (start) begin
      cnt <= lat_load;
    end else if (state == ST_COUNT) begin
      cnt <= cnt - lat_cnt_t'(1);
    end
  end

  assign muldiv_busy = (state == ST_COUNT);
  // One-cycle pulse in the last EX cycle
  assign muldiv_done = last;
  // Release the entry on done so it retires that cycle
  assign hold_idex   = idex_is_mul_div && !last;

endmodule

`default_nettype wire

// ==== verilog/pipe_front_top.sv ====
////////////////////////////////////////////////////////////
// Pipeline front end top level
// Fetch, decode and EX hold with hazard and M-unit control
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pipe_front_top (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_isa_pkg::instr_t imem_rdata,
  output pipe_ctrl_pkg::pc_t imem_addr,
  output logic               retire_valid,
  output pipe_ctrl_pkg::pc_t retire_pc,
  output rv_isa_pkg::instr_t retire_instr
);

  import rv_isa_pkg::*;
  import pipe_ctrl_pkg::*;

  // IF/ID
  logic       ifid_valid;
  pc_t        ifid_pc;
  instr_t     ifid_instr;
  reg_idx_t   ifid_rs1;
  reg_idx_t   ifid_rs2;

  // ID/EX side toward control
  logic       idex_mem_read;
  logic       idex_is_mul_div;
  reg_idx_t   idex_rd;
  logic [2:0] idex_funct3;

  // Control
  logic       stall_pc;
  logic       stall_ifid;
  logic       bubble_idex;
  logic       muldiv_busy;
  logic       muldiv_done;
  logic       hold_idex;

  fetch_stage u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall_pc   (stall_pc),
    .stall_ifid (stall_ifid),
    .imem_rdata (imem_rdata),
    .imem_addr  (imem_addr),
    .ifid_valid (ifid_valid),
    .ifid_pc    (ifid_pc),
    .ifid_instr (ifid_instr)
  );

  decode_stage u_decode (
    .clk             (clk),
    .rst_n           (rst_n),
    .ifid_valid      (ifid_valid),
    .ifid_pc         (ifid_pc),
    .ifid_instr      (ifid_instr),
    .bubble_idex     (bubble_idex),
    .hold_idex       (hold_idex),
    .ifid_rs1        (ifid_rs1),
    .ifid_rs2        (ifid_rs2),
    .idex_mem_read   (idex_mem_read),
    .idex_is_mul_div (idex_is_mul_div),
    .idex_rd         (idex_rd),
    .idex_funct3     (idex_funct3),
    .retire_valid    (retire_valid),
    .retire_pc       (retire_pc),
    .retire_instr    (retire_instr)
  );

  hazard_detection_unit u_hazard (
    .idex_mem_read   (idex_mem_read),
    .idex_rd         (idex_rd),
    .ifid_rs1        (ifid_rs1),
    .ifid_rs2        (ifid_rs2),
    .muldiv_busy     (muldiv_busy),
    .muldiv_done     (muldiv_done),
    .idex_is_mul_div (idex_is_mul_div),
    .stall_pc        (stall_pc),
    .stall_ifid      (stall_ifid),
    .bubble_idex     (bubble_idex)
  );

  muldiv_sequencer u_muldiv_seq (
    .clk             (clk),
    .rst_n           (rst_n),
    .idex_is_mul_div (idex_is_mul_div),
    .idex_funct3     (idex_funct3),
    .muldiv_busy     (muldiv_busy),
    .muldiv_done     (muldiv_done),
    .hold_idex       (hold_idex)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////
// Testbench clock generator
// Free-running clock with a 10 ns period
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  // Half period of 5 ns
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== tb/pipe_front_tb.sv ====
////////////////////////////////////////////////////////////
// Pipeline front end testbench
// Program table with expected stalls, ROM model, retire
// trace checks against program order and cycle gaps
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pipe_front_tb;

  import rv_isa_pkg::*;
  import pipe_ctrl_pkg::*;

  localparam int PROG_LEN       = 23;
  localparam int NUM_TESTS      = 6;
  localparam int TIMEOUT_CYCLES = PROG_LEN * (DIV_CYCLES + 3) + 20;

  // Slot kinds
  localparam int K_ALU     = 0;
  localparam int K_LOAD    = 1;
  localparam int K_USE_RS1 = 2;
  localparam int K_USE_RS2 = 3;
  localparam int K_LOAD_X0 = 4;
  localparam int K_READ_X0 = 5;
  localparam int K_MUL     = 6;
  localparam int K_DIV     = 7;

  logic     clk;
  logic     rst_n;
  instr_t   imem_rdata;
  pc_t      imem_addr;
  logic     retire_valid;
  pc_t      retire_pc;
  instr_t   retire_instr;

  // Program table and ROM image
  int       slot_test  [PROG_LEN];
  int       slot_kind  [PROG_LEN];
  int       slot_stall [PROG_LEN];
  instr_t   rom        [PROG_LEN];
  string    test_name  [1:NUM_TESTS];
  int       test_err   [1:NUM_TESTS];

  int       seed = 9;
  int       nslots = 0;
  reg_idx_t load_rd;
  instr_t   word;

  // Scoreboard state
  int       ret_idx = 0;
  int       cycle = 0;
  int       last_ret_cycle = 0;
  int       cur_test = 1;
  int       errors = 0;
  int       checks = 0;
  int       tests_done = 0;
  pc_t      exp_pc;

  tb_clock_gen clk_gen (
    .clk (clk)
  );

  pipe_front_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_rdata   (imem_rdata),
    .imem_addr    (imem_addr),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr)
  );

  // Combinational instruction memory that returns NOP past the program
  assign imem_rdata = (imem_addr[31:2] < PROG_LEN) ? rom[imem_addr[31:2]] : NOP_INSTR;

  task automatic add_slot(input int test, input int kind, input int stall);
    slot_test[nslots]  = test;
    slot_kind[nslots]  = kind;
    slot_stall[nslots] = stall;
    nslots++;
  endtask

  // Sources of fillers stay in x1..x15, load targets in x16..x31
  task automatic build_word(input int kind, output instr_t w);
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    rd  = $random(seed);
    rs1 = 1 + ({$random(seed)} % 15);
    rs2 = 1 + ({$random(seed)} % 15);
    case (kind)
      K_ALU:     w = {7'b0, rs2, rs1, 3'b000, rd, OPC_OP};
      K_LOAD: begin
        load_rd = 16 + ({$random(seed)} % 16);
        w = {12'h000, rs1, 3'b010, load_rd, OPC_LOAD};
      end
      K_USE_RS1: w = {7'b0, rs2, load_rd, 3'b000, rd, OPC_OP};
      K_USE_RS2: w = {7'b0, load_rd, rs1, 3'b000, rd, OPC_OP};
      K_LOAD_X0: w = {12'h000, rs1, 3'b010, 5'd0, OPC_LOAD};
      K_READ_X0: w = {7'b0, 5'd0, 5'd0, 3'b000, rd, OPC_OP};
      K_MUL:     w = {FUNCT7_MULDIV, rs2, rs1, F3_MUL, rd, OPC_OP};
      K_DIV:     w = {FUNCT7_MULDIV, rs2, rs1, F3_DIV_FIRST, rd, OPC_OP};
      default:   w = NOP_INSTR;
    endcase
  endtask

  task automatic check_pc(input string what, input pc_t got, input pc_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_err[cur_test]++;
      $display("Error: t=%0t %s %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_instr(input instr_t got, input instr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_err[cur_test]++;
      $display("Error: t=%0t retire_instr %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_gap(input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      test_err[cur_test]++;
      $display("Error: t=%0t retire gap %0d cycles, expected %0d", $time, got, exp);
    end
  endtask

  task automatic report_test(input int t);
    tests_done++;
    if (test_err[t] == 0) begin
      $display("Test %0d %s: ok", t, test_name[t]);
    end else begin
      $display("Test %0d %s: %0d mismatches", t, test_name[t], test_err[t]);
    end
  endtask

  // Retire monitor sampling mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (!rst_n) begin
      if (retire_valid === 1'b1) begin
        errors++;
        test_err[1]++;
        $display("Error: t=%0t retire_valid set during reset", $time);
      end
    end else begin
      cycle++;
      if (retire_valid === 1'b1 && ret_idx < PROG_LEN) begin
        cur_test = slot_test[ret_idx];
        exp_pc   = ret_idx * PC_STEP;
        check_pc("retire_pc", retire_pc, exp_pc);
        check_instr(retire_instr, rom[ret_idx]);
        // One cycle per retire plus the stall in front of this slot
        if (ret_idx > 0) begin
          check_gap(cycle - last_ret_cycle, 1 + slot_stall[ret_idx]);
        end
        last_ret_cycle = cycle;
        if (ret_idx == PROG_LEN - 1 || slot_test[ret_idx + 1] != cur_test) begin
          report_test(cur_test);
        end
        ret_idx++;
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    test_name[1] = "reset";
    test_name[2] = "independent";
    test_name[3] = "load-use";
    test_name[4] = "load x0";
    test_name[5] = "mul div";
    test_name[6] = "back-to-back M";
    for (int t = 1; t <= NUM_TESTS; t++) begin
      test_err[t] = 0;
    end

    // Test, kind, stall cycles ahead of the slot
    add_slot(1, K_ALU, 0);
    for (int i = 0; i < 5; i++) begin
      add_slot(2, K_ALU, 0);
    end
    add_slot(3, K_LOAD, 0);
    add_slot(3, K_USE_RS1, 1);
    add_slot(3, K_ALU, 0);
    add_slot(3, K_LOAD, 0);
    add_slot(3, K_USE_RS2, 1);
    add_slot(3, K_ALU, 0);
    add_slot(4, K_LOAD_X0, 0);
    add_slot(4, K_READ_X0, 0);
    add_slot(4, K_ALU, 0);
    add_slot(5, K_MUL, MUL_CYCLES - 1);
    add_slot(5, K_ALU, 0);
    add_slot(5, K_DIV, DIV_CYCLES - 1);
    add_slot(5, K_ALU, 0);
    add_slot(6, K_MUL, MUL_CYCLES - 1);
    add_slot(6, K_DIV, DIV_CYCLES - 1);
    add_slot(6, K_MUL, MUL_CYCLES - 1);
    add_slot(6, K_ALU, 0);

    for (int i = 0; i < PROG_LEN; i++) begin
      build_word(slot_kind[i], word);
      rom[i] = word;
    end

    repeat (3) @(posedge clk);
    // PC parked at the reset vector while reset is held
    @(negedge clk);
    check_pc("imem_addr", imem_addr, RESET_PC);
    @(posedge clk);
    rst_n <= 1'b1;

    while (ret_idx < PROG_LEN && cycle < TIMEOUT_CYCLES) begin
      @(posedge clk);
    end

    if (ret_idx < PROG_LEN) begin
      $display("Timeout: only %0d of %0d instructions retired in %0d cycles",
               ret_idx, PROG_LEN, cycle);
      $display("Result: FAILED");
    end else begin
      $display("Done: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      if (errors == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== pipe_front.f ====
verilog/rv_isa_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/hazard_detection_unit.sv
verilog/muldiv_sequencer.sv
verilog/pipe_front_top.sv
tb/tb_clock_gen.sv
tb/pipe_front_tb.sv
